//--- Makefile
# Verilator build and run of the data cache testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module dcacheTb -f project.f -o dcacheSim
	./obj_dir/dcacheSim | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dcacheChecker.sv
// Data cache response checker
// keeps a flat byte model of memory, checks every load and the status handshake
`timescale 1ns/100ps
`include "dcacheConsts.svh"

module dcacheChecker
(
	input logic clock,
	input logic reset,
	input dcachePkg::dcAddr reqAddr,
	input dcachePkg::dcOpm reqOpm,
	input dcachePkg::dcWord reqValue,
	input dcachePkg::dcWord respValue,
	input dcachePkg::dcStatus respOk,
	input dcachePkg::dcAddr memAddr,
	input dcachePkg::dcOpm memOpm,
	input dcachePkg::dcStatus memOk,
	input int testId,
	input int issued,
	output int errorCount,
	output logic summaryDone
);

	import dcachePkg::*;

	logic [7:0] model [16384];	// the 16 KiB address window
	logic [63:0] flushedIdx;	// indices whose next access must miss
	logic readSeen;
	logic lastOk;
	logic afterReset;
	int currentTest;
	int testChecks;
	int testErrors;
	int totalChecks;
	int okCount;
	int writeBacks;

	function automatic logic [7:0] fillByte(input dcAddr a);
		return (a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]) + 8'h3C;
	endfunction

	function automatic string testName(input int id);
		case (id)
			1: return "random loads";
			2: return "store then load";
			3: return "aliasing stores";
			4: return "flush sweep";
			default: return "mixed traffic";
		endcase
	endfunction

	function automatic dcWord expectedLoad(input dcAddr a, input dcOpm opm);
		int bytes;
		int i;
		logic [13:0] b;
		dcWord v;
		bytes = 1 << opm[1:0];
		v = '0;
		for (i = 0; i < bytes; i++)
		begin
			b = a[13:0] + 14'(i);
			v[8*i +: 8] = model[b];
		end
		// bit 2 clear means signed, dword needs no extension
		if (!opm[2] && (bytes < 8) && v[8*bytes-1])
			v = v | ~((64'd1 << (8*bytes)) - 64'd1);
		return v;
	endfunction

	function automatic void writeModel(input dcAddr a, input dcOpm opm, input dcWord value);
		int i;
		logic [13:0] b;
		for (i = 0; i < (1 << opm[1:0]); i++)
		begin
			b = a[13:0] + 14'(i);
			model[b] = value[8*i +: 8];
		end
	endfunction

	task automatic reportProblem(input string msg);
		$display("ERROR %s: %s", testName(currentTest), msg);
		errorCount++;
		testErrors++;
	endtask

	task automatic checkResponse();
		dcWord expected;
		if (lastOk)
			reportProblem("respOk was OK for two cycles in a row");
		okCount++;
		testChecks++;
		totalChecks++;
		if (reqOpm == `DC_OPM_READY)
			reportProblem("OK arrived with no request pending");
		else if (reqOpm == `DC_OPM_FLUSH)
			flushedIdx = '1;
		else
		begin
			if (flushedIdx[reqAddr[9:4]] && !readSeen)
				reportProblem("access to a flushed index finished without a memory read");
			flushedIdx[reqAddr[9:4]] = 1'b0;
			if (reqOpm[4])
				writeModel(reqAddr, reqOpm, reqValue);
			else
			begin
				expected = expectedLoad(reqAddr, reqOpm);
				if (respValue !== expected)
				begin
					$display("FAILED %s: load %h at %h expected %h actual %h",
						testName(currentTest), reqOpm, reqAddr, expected, respValue);
					errorCount++;
					testErrors++;
				end
			end
		end
		readSeen = 1'b0;
	endtask

	task automatic closeTest();
		if (currentTest != 0)
		begin
			if ((currentTest == 3) && (writeBacks == 0))
				reportProblem("no dirty line was written back");
			$display("test %0d %s: %0d checks, %0d errors",
				currentTest, testName(currentTest), testChecks, testErrors);
		end
		if (testId == 0)
		begin
			if (okCount != issued)
				reportProblem($sformatf("%0d requests issued but %0d OK responses",
					issued, okCount));
			$display("%0d requests, %0d checks, %0d errors", issued, totalChecks, errorCount);
			summaryDone <= 1'b1;
		end
		currentTest = testId;
		testChecks = 0;
		testErrors = 0;
		writeBacks = 0;
	endtask

	initial
	begin
		for (int a = 0; a < 16384; a++)
			model[14'(a)] = fillByte(dcAddr'(a));
		flushedIdx = '1;	// reset flushes every index
		readSeen = 1'b0;
		lastOk = 1'b0;
		afterReset = 1'b0;
		currentTest = 0;
		testChecks = 0;
		testErrors = 0;
		totalChecks = 0;
		okCount = 0;
		writeBacks = 0;
		errorCount = 0;
		summaryDone = 1'b0;
		forever
		begin
			@(posedge clock);
			if (reset)
			begin
				afterReset = 1'b1;
				flushedIdx = '1;
				lastOk = 1'b0;
			end
			else
			begin
				if (afterReset && ((respOk != `DC_OK_READY) || (memOpm != `DC_OPM_READY)))
					reportProblem("cache was not idle right after reset");
				afterReset = 1'b0;
				if ((memOpm == `DC_OPM_RD_TILE) && (memOk == `DC_OK_OK))
				begin
					// the refill fetches the line of the pending request
					if (memAddr != {reqAddr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}})
						reportProblem("memory read was not for the requested line");
					readSeen = 1'b1;
				end
				if ((memOpm == `DC_OPM_WR_TILE) && (memOk == `DC_OK_OK))
				begin
					if (memAddr[9:4] != reqAddr[9:4])
						reportProblem("write-back was not from the requested index");
					writeBacks++;
				end
				if (respOk == `DC_OK_OK)
					checkResponse();
				lastOk = (respOk == `DC_OK_OK);
				if (testId != currentTest)
					closeTest();
			end
		end
	end

endmodule

//--- dcacheConsts.svh
// Data cache constants
// widths, cache geometry, operation modes and status codes
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define DC_ADDR_W	32
`define DC_DATA_W	64
`define DC_LINE_W	128
// 64 lines, 16 bytes each
`define DC_INDEX_W	6
`define DC_OFFSET_W	4
`define DC_OPM_W	5

// control operations have bits 4:3 clear
`define DC_OPM_READY	5'h00
`define DC_OPM_FLUSH	5'h01
`define DC_OPM_RD_TILE	5'h02
`define DC_OPM_WR_TILE	5'h03
// access groups, the low three bits give size and extension
`define DC_OPM_LOAD		5'h08
`define DC_OPM_STORE	5'h10

`define DC_OK_READY	2'b00
`define DC_OK_OK	2'b01
`define DC_OK_HOLD	2'b10

`endif

//--- dcachePkg.sv
// Data cache shared types
// addresses, lines, tag entries and status values
`include "dcacheConsts.svh"

package dcachePkg;

	typedef logic [`DC_ADDR_W-1:0] dcAddr;
	typedef logic [`DC_DATA_W-1:0] dcWord;
	typedef logic [`DC_LINE_W-1:0] dcLine;
	typedef logic [`DC_INDEX_W-1:0] dcIndex;

	// address bits above index and offset
	typedef logic [`DC_ADDR_W-`DC_INDEX_W-`DC_OFFSET_W-1:0] dcTag;

	// valid is only ever written as 1, the flush mask does the invalidation
	typedef struct packed
	{
		dcTag tag;
		logic valid;
		logic dirty;
	} dcTagEntry;

	typedef logic [`DC_OPM_W-1:0] dcOpm;
	typedef logic [1:0] dcStatus;

endpackage

//--- dcacheTb.sv
// Data cache testbench
// random loads, stores and flushes, with a line-wide memory behind the cache
`timescale 1ns/100ps
`include "dcacheConsts.svh"

module dcacheTb;

	import dcachePkg::*;

	localparam int LOAD_COUNT = 150;
	localparam int PAIR_COUNT = 100;
	localparam int ALIAS_COUNT = 80;
	localparam int MIX_COUNT = 100;
	localparam int REQUEST_TOTAL =
		LOAD_COUNT + 2 * PAIR_COUNT + 2 * ALIAS_COUNT + 4 * 64 + 1 + MIX_COUNT;

	logic clock;
	logic reset;
	dcAddr reqAddr;
	dcOpm reqOpm;
	dcWord reqValue;
	dcWord respValue;
	dcStatus respOk;
	dcAddr memAddr;
	dcOpm memOpm;
	dcLine memDataOut;
	dcLine memDataIn;
	dcStatus memOk;
	int seed;
	int testId;
	int issued;
	int errorCount;
	int holdCount;
	logic answer;
	logic summaryDone;
	dcLine mem [1024];	// one entry per line of the window

	dcacheTop uut
	(
		.clock(clock), .reset(reset), .reqAddr(reqAddr), .reqOpm(reqOpm),
		.reqValue(reqValue), .respValue(respValue), .respOk(respOk),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataIn(memDataIn), .memOk(memOk)
	);

	dcacheChecker check
	(
		.clock(clock), .reset(reset), .reqAddr(reqAddr), .reqOpm(reqOpm),
		.reqValue(reqValue), .respValue(respValue), .respOk(respOk),
		.memAddr(memAddr), .memOpm(memOpm), .memOk(memOk), .testId(testId),
		.issued(issued), .errorCount(errorCount), .summaryDone(summaryDone)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [7:0] fillByte(input dcAddr a);
		return (a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24]) + 8'h3C;
	endfunction

	function automatic dcAddr alignTo(input dcAddr a, input logic [1:0] size);
		return a & ~((dcAddr'(1) << size) - dcAddr'(1));
	endfunction

	function automatic dcAddr pickAddr(input logic [1:0] size);
		int r;
		r = $random(seed);
		return alignTo(dcAddr'(r & 32'h3FFF), size);
	endfunction

	function automatic dcOpm pickLoadMode();
		int r;
		r = $random(seed);
		return `DC_OPM_LOAD | dcOpm'((r & 32'h7FFF_FFFF) % 7);	// seven load modes
	endfunction

	function automatic dcWord pickValue();
		int hi;
		int lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	// hold the request until the cache answers OK
	task automatic issue(input dcAddr addr, input dcOpm opm, input dcWord value);
		reqAddr <= addr;
		reqOpm <= opm;
		reqValue <= value;
		issued <= issued + 1;
		do
			@(posedge clock);
		while (respOk != `DC_OK_OK);
	endtask

	task automatic randomLoads();
		dcOpm mode;
		testId <= 1;
		repeat (LOAD_COUNT)
		begin
			mode = pickLoadMode();
			issue(pickAddr(mode[1:0]), mode, '0);
		end
	endtask

	task automatic storeThenLoad();
		int r;
		logic [1:0] size;
		dcAddr addr;
		testId <= 2;
		repeat (PAIR_COUNT)
		begin
			r = $random(seed);
			size = r[1:0];
			addr = pickAddr(size);
			issue(addr, `DC_OPM_STORE | dcOpm'(size), pickValue());
			// unsigned variant only below dword
			issue(addr, `DC_OPM_LOAD | dcOpm'({r[2] && (size != 2'd3), size}), '0);
		end
	endtask

	task automatic aliasStores();
		dcAddr addrs[$];
		logic [1:0] sizes[$];
		int r;
		int k;
		testId <= 3;
		for (k = 0; k < ALIAS_COUNT; k++)
		begin
			r = $random(seed);
			sizes.push_back(r[5:4]);
			// 16 tags over 8 indices
			addrs.push_back(alignTo(dcAddr'(((r & 15) << 10) | ((k % 8) << 7) | ((r >> 8) & 15)),
				r[5:4]));
			issue(addrs[k], `DC_OPM_STORE | dcOpm'(r[5:4]), pickValue());
		end
		for (k = 0; k < ALIAS_COUNT; k++)
			issue(addrs[k], `DC_OPM_LOAD | dcOpm'(sizes[k]), '0);
	endtask

	task automatic flushSweep();
		dcAddr firstAddr[64];
		dcAddr secondAddr[64];
		int r;
		int i;
		testId <= 4;
		for (i = 0; i < 64; i++)
		begin
			r = $random(seed);
			firstAddr[i] = dcAddr'(((r & 15) << 10) | (i << 4) | (r & 8));
			secondAddr[i] = dcAddr'(((((r & 15) + 1 + ((r >> 4) & 7)) & 15) << 10) | (i << 4));
			issue(firstAddr[i], `DC_OPM_STORE | 5'd3, pickValue());
		end
		for (i = 0; i < 64; i++)
			issue(secondAddr[i], pickLoadMode(), '0);	// evicts the dirty line
		issue('0, `DC_OPM_FLUSH, '0);
		for (i = 0; i < 64; i++)
			issue(secondAddr[i], pickLoadMode(), '0);
		for (i = 0; i < 64; i++)
			issue(firstAddr[i], `DC_OPM_LOAD | 5'd3, '0);
	endtask

	task automatic mixedTraffic();
		int r;
		dcOpm mode;
		testId <= 5;
		repeat (MIX_COUNT)
		begin
			r = $random(seed);
			mode = pickLoadMode();
			if ((r & 15) == 0)
				issue('0, `DC_OPM_FLUSH, '0);
			else if (r[4])
				issue(pickAddr(r[9:8]), `DC_OPM_STORE | dcOpm'(r[9:8]), pickValue());
			else
				issue(pickAddr(mode[1:0]), mode, '0);
		end
	endtask

	// memory model, answers after 0 to 3 HOLD cycles
	initial
	begin
		memOk = `DC_OK_READY;
		memDataIn = '0;
		holdCount = 0;
		for (int i = 0; i < 1024; i++)
			for (int j = 0; j < 16; j++)
				mem[10'(i)][8*j +: 8] = fillByte(dcAddr'(i * 16 + j));
		forever
		begin
			@(posedge clock);
			answer = 1'b0;
			if (reset)
				memOk <= `DC_OK_READY;
			else if (memOk == `DC_OK_READY)
			begin
				if ((memOpm == `DC_OPM_RD_TILE) || (memOpm == `DC_OPM_WR_TILE))
				begin
					holdCount = $random(seed) & 3;
					answer = (holdCount == 0);
					if (holdCount != 0)
						memOk <= `DC_OK_HOLD;
				end
			end
			else if (memOk == `DC_OK_HOLD)
			begin
				holdCount = holdCount - 1;
				answer = (holdCount == 0);
			end
			else if (memOpm == `DC_OPM_READY)
				memOk <= `DC_OK_READY;
			if (answer)
			begin
				if (memOpm == `DC_OPM_RD_TILE)
					memDataIn <= mem[memAddr[13:4]];
				else
					mem[memAddr[13:4]] <= memDataOut;
				memOk <= `DC_OK_OK;
			end
		end
	end

	initial
	begin
		repeat (400 * REQUEST_TOTAL) @(posedge clock);
		$display("timeout: the cache stopped answering requests");
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		seed = 32'h60722def;
		reset = 1'b1;
		reqAddr = '0;
		reqOpm = `DC_OPM_READY;
		reqValue = '0;
		testId = 0;
		issued = 0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		randomLoads();
		storeThenLoad();
		aliasStores();
		flushSweep();
		mixedTraffic();
		testId <= 0;
		reqOpm <= `DC_OPM_READY;
		do
			@(posedge clock);
		while (!summaryDone);
		if (errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- dcacheTop.sv
// Direct-mapped write-back L1 data cache
// one request at a time, misses go through the miss sequencer
`timescale 1ns/100ps
`include "dcacheConsts.svh"

module dcacheTop
(
	input logic clock,
	input logic reset,
	input dcachePkg::dcAddr reqAddr,
	input dcachePkg::dcOpm reqOpm,
	input dcachePkg::dcWord reqValue,
	output dcachePkg::dcWord respValue,
	output dcachePkg::dcStatus respOk,
	output dcachePkg::dcAddr memAddr,
	output dcachePkg::dcOpm memOpm,
	output dcachePkg::dcLine memDataOut,
	input dcachePkg::dcLine memDataIn,
	input dcachePkg::dcStatus memOk
);

	import dcachePkg::*;

	typedef enum logic [2:0] {sIdle, sRead, sCompare, sStore, sMiss} topState;

	topState state;
	dcAddr addrReg;
	dcOpm opmReg;
	dcWord valueReg;
	dcIndex reqIndex;
	dcTag reqTag;
	dcLine dataRead, mergedLine, fillLine, writeLine;
	dcTagEntry tagRead, writeTag;
	logic [(1 << `DC_INDEX_W)-1:0] flushMask;
	logic [(1 << `DC_INDEX_W)-1:0] filledMask;	// ever refilled since reset
	logic isAccess, isStore, isFlush, hit, writeEnable, missStart, fillDone;

	assign reqIndex = addrReg[`DC_OFFSET_W +: `DC_INDEX_W];
	assign reqTag = addrReg[`DC_ADDR_W-1:`DC_OFFSET_W+`DC_INDEX_W];
	assign isStore = opmReg[4];
	assign isAccess = opmReg[4] | opmReg[3];
	assign isFlush = (opmReg == `DC_OPM_FLUSH);

	// a flushed index never hits, whatever the tag array holds
	assign hit = !flushMask[reqIndex] && tagRead.valid && (tagRead.tag == reqTag);
	assign missStart = (state == sCompare) && isAccess && !hit;

	assign writeEnable = (state == sStore) || fillDone;
	assign writeLine = fillDone ? fillLine : mergedLine;
	assign writeTag = '{tag: reqTag, valid: 1'b1, dirty: (state == sStore)};

	always_comb
	begin
		case (state)
			sIdle: respOk = `DC_OK_READY;
			sCompare: respOk = (!isAccess || (hit && !isStore)) ? `DC_OK_OK : `DC_OK_HOLD;
			sStore: respOk = `DC_OK_OK;
			default: respOk = `DC_OK_HOLD;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= sIdle;
			flushMask <= '1;	// reset counts as a full flush
			filledMask <= '0;
		end
		else
		begin
			case (state)
				sIdle:
					if (reqOpm != `DC_OPM_READY)
						state <= sRead;
				sRead: state <= sCompare;
				sCompare:
					if (!isAccess)
						state <= sIdle;
					else if (!hit)
						state <= sMiss;
					else
						state <= isStore ? sStore : sIdle;
				sStore: state <= sIdle;
				default:
					if (fillDone)
						state <= sRead;	// retry as a hit
			endcase
			if ((state == sCompare) && isFlush)
				flushMask <= '1;
			else if (fillDone)
				flushMask[reqIndex] <= 1'b0;
			if (fillDone)
				filledMask[reqIndex] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == sIdle)
		begin
			addrReg <= reqAddr;
			opmReg <= reqOpm;
			valueReg <= reqValue;
		end
	end

	lineArray #(.entryType(dcLine)) dataArray
	(
		.clock(clock), .readIndex(reqIndex), .readEntry(dataRead),
		.writeEnable(writeEnable), .writeIndex(reqIndex), .writeEntry(writeLine)
	);

	lineArray #(.entryType(dcTagEntry)) tagArray
	(
		.clock(clock), .readIndex(reqIndex), .readEntry(tagRead),
		.writeEnable(writeEnable), .writeIndex(reqIndex), .writeEntry(writeTag)
	);

	lineAccess access
	(
		.line(dataRead), .offset(addrReg[`DC_OFFSET_W-1:0]), .opm(opmReg),
		.storeValue(valueReg), .loadValue(respValue), .mergedLine(mergedLine)
	);

	// dirty data survives a flush and is still written back
	missEngine engine
	(
		.clock(clock), .reset(reset), .start(missStart),
		.victimDirty(filledMask[reqIndex] && tagRead.dirty),
		.victimLine(dataRead),
		.victimAddr({tagRead.tag, reqIndex, {`DC_OFFSET_W{1'b0}}}),
		.fillAddr({reqTag, reqIndex, {`DC_OFFSET_W{1'b0}}}),
		.fillDone(fillDone), .fillLine(fillLine),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataIn(memDataIn), .memOk(memOk)
	);

	// the core moves on after one OK, so OK never repeats for the same request
	singleOk: assert property (@(posedge clock) disable iff (reset)
		(respOk == `DC_OK_OK) |=> ((respOk != `DC_OK_OK) || $changed(reqOpm)));

endmodule

//--- lineAccess.sv
// Line access datapath
// picks the addressed bytes for loads, merges store data into the line
`timescale 1ns/100ps
`include "dcacheConsts.svh"

module lineAccess
(
	input dcachePkg::dcLine line,
	input logic [`DC_OFFSET_W-1:0] offset,
	input dcachePkg::dcOpm opm,
	input dcachePkg::dcWord storeValue,
	output dcachePkg::dcWord loadValue,
	output dcachePkg::dcLine mergedLine
);

	import dcachePkg::*;

	dcLine shifted;
	dcWord raw;
	dcWord sizeMask;
	dcLine laneMask;
	dcLine storeShifted;

	always_comb
	begin
		shifted = line >> {offset, 3'b000};
		raw = shifted[`DC_DATA_W-1:0];

		case (opm[2:0])
			3'd0: loadValue = {{(`DC_DATA_W-8){raw[7]}}, raw[7:0]};
			3'd1: loadValue = {{(`DC_DATA_W-16){raw[15]}}, raw[15:0]};
			3'd2: loadValue = {{(`DC_DATA_W-32){raw[31]}}, raw[31:0]};
			3'd4: loadValue = {{(`DC_DATA_W-8){1'b0}}, raw[7:0]};
			3'd5: loadValue = {{(`DC_DATA_W-16){1'b0}}, raw[15:0]};
			3'd6: loadValue = {{(`DC_DATA_W-32){1'b0}}, raw[31:0]};
			default: loadValue = raw;	// dword
		endcase
	end

	always_comb
	begin
		// store size only needs the low two bits
		case (opm[1:0])
			2'd0: sizeMask = dcWord'(8'hFF);
			2'd1: sizeMask = dcWord'(16'hFFFF);
			2'd2: sizeMask = dcWord'(32'hFFFF_FFFF);
			default: sizeMask = '1;
		endcase

		laneMask = dcLine'(sizeMask) << {offset, 3'b000};
		storeShifted = dcLine'(storeValue) << {offset, 3'b000};
		mergedLine = (line & ~laneMask) | (storeShifted & laneMask);
	end

endmodule

//--- lineArray.sv
// Line storage array
// registered read, write-first when both ports hit the same index
`timescale 1ns/100ps
`include "dcacheConsts.svh"

module lineArray
#(
	parameter type entryType = dcachePkg::dcLine,
	parameter int DEPTH = (1 << `DC_INDEX_W)
)
(
	input logic clock,
	input dcachePkg::dcIndex readIndex,
	output entryType readEntry,
	input logic writeEnable,
	input dcachePkg::dcIndex writeIndex,
	input entryType writeEntry
);

	entryType store [DEPTH];

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			store[writeIndex] <= writeEntry;

		// forward the entry being written, so a reread sees the new value
		if (writeEnable && (writeIndex == readIndex))
			readEntry <= writeEntry;
		else
			readEntry <= store[readIndex];
	end

	// no unknown bits may reach the array from the cache control
	writeKnown: assert property (@(posedge clock)
		writeEnable |-> !$isunknown(writeEntry));

endmodule

//--- missEngine.sv
// Miss sequencer
// writes back a dirty victim, then reads the new line on the memory port
`timescale 1ns/100ps
`include "dcacheConsts.svh"

module missEngine
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic victimDirty,
	input dcachePkg::dcLine victimLine,
	input dcachePkg::dcAddr victimAddr,
	input dcachePkg::dcAddr fillAddr,
	output logic fillDone,
	output dcachePkg::dcLine fillLine,
	output dcachePkg::dcAddr memAddr,
	output dcachePkg::dcOpm memOpm,
	output dcachePkg::dcLine memDataOut,
	input dcachePkg::dcLine memDataIn,
	input dcachePkg::dcStatus memOk
);

	import dcachePkg::*;

	typedef enum logic [2:0]
	{
		sIdle,
		sWbIssue,
		sWbRelease,
		sRdIssue,
		sRdRelease,
		sDone
	} engineState;

	engineState state;
	dcAddr refillAddr;

	assign fillDone = (state == sDone);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= sIdle;
			memOpm <= `DC_OPM_READY;
		end
		else
		begin
			case (state)
				sIdle:
					if (start)
						state <= victimDirty ? sWbIssue : sRdIssue;
				sWbIssue:
					if (memOpm == `DC_OPM_READY)
					begin
						if (memOk == `DC_OK_READY)
							memOpm <= `DC_OPM_WR_TILE;
					end
					else if (memOk == `DC_OK_OK)
					begin
						memOpm <= `DC_OPM_READY;
						state <= sWbRelease;
					end
				sWbRelease:
					if (memOk == `DC_OK_READY)
						state <= sRdIssue;
				sRdIssue:
					if (memOpm == `DC_OPM_READY)
					begin
						if (memOk == `DC_OK_READY)
							memOpm <= `DC_OPM_RD_TILE;
					end
					else if (memOk == `DC_OK_OK)
					begin
						memOpm <= `DC_OPM_READY;
						state <= sRdRelease;
					end
				sRdRelease:
					if (memOk == `DC_OK_READY)
						state <= sDone;
				default:
					state <= sIdle;	// done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == sIdle) && start)
		begin
			memAddr <= victimDirty ? victimAddr : fillAddr;
			memDataOut <= victimLine;
			refillAddr <= fillAddr;
		end
		if (state == sWbRelease)
			memAddr <= refillAddr;	// read follows the write-back
		if ((state == sRdIssue) && (memOpm != `DC_OPM_READY) && (memOk == `DC_OK_OK))
			fillLine <= memDataIn;
	end

	// memory holds us off, so the operation must stay put meanwhile
	opmStable: assert property (@(posedge clock) disable iff (reset)
		$changed(memOpm) |-> ($past(memOk) != `DC_OK_HOLD));

	startIdle: assert property (@(posedge clock) disable iff (reset)
		start |-> (state == sIdle));

endmodule

//--- project.f
+incdir+.
dcachePkg.sv
lineArray.sv
lineAccess.sv
missEngine.sv
dcacheTop.sv
dcacheChecker.sv
dcacheTb.sv
